// File: Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f uart.f --top-module uart_tb
	./obj_dir/Vuart_tb | tee /dev/stderr | grep "Simulation completed successfully" > /dev/null

lint:
	verilator --lint-only -Wall --timing -f uart.f --top-module uart_tb

clean:
	rm -rf obj_dir

// File: logic/uart.sv
module uart (
  input  logic        clock,
  input  logic        reset,
  input  logic        cyc,
  input  logic        stb,
  input  logic        we,
  input  logic [2:0]  adr,
  input  logic [31:0] dat_i,
  output logic [31:0] dat_o,
  output logic        ack,
  input  logic        rxd,
  output logic        txd,
  output logic        interrupt
);
  import uart_pkg::*;

  logic                   capture;
  logic                   bank_wr;
  logic                   bank_rd;
  logic [2:0]             adr_q;
  logic [31:0]            dat_q;
  logic                   txen;
  logic                   rxen;
  logic                   nstop;
  logic [15:0]            div;
  logic                   tx_push;
  logic [7:0]             tx_push_data;
  logic                   tx_pop;
  logic [7:0]             tx_head;
  logic [level_width-1:0] tx_level;
  logic                   tx_full;
  logic                   tx_empty;
  logic                   rx_push;
  logic [7:0]             rx_byte;
  logic                   rx_pop;
  logic [7:0]             rx_pop_data;
  logic [level_width-1:0] rx_level;
  logic                   rx_empty;

  // Bus inputs registered ahead of the bank
  always_ff @(posedge clock) begin
    if (capture) begin
      adr_q <= adr;
      dat_q <= dat_i;
    end
  end

  uart_fsm fsm (
    .clock(clock), .reset(reset), .cyc(cyc), .stb(stb), .we(we),
    .capture(capture), .bank_wr(bank_wr), .bank_rd(bank_rd), .ack(ack)
  );

  uart_bank bank (
    .clock(clock), .reset(reset), .bank_wr(bank_wr), .bank_rd(bank_rd),
    .addr(adr_q), .wr_data(dat_q), .rd_data(dat_o),
    .txen(txen), .rxen(rxen), .nstop(nstop), .div(div),
    .tx_push(tx_push), .tx_push_data(tx_push_data),
    .rx_pop(rx_pop), .rx_pop_data(rx_pop_data),
    .tx_level(tx_level), .tx_full(tx_full),
    .rx_level(rx_level), .rx_empty(rx_empty), .interrupt(interrupt)
  );

  uart_fifo tx_fifo (
    .clock(clock), .reset(reset), .push(tx_push), .push_data(tx_push_data),
    .pop(tx_pop), .pop_data(tx_head), .level(tx_level),
    .full(tx_full), .empty(tx_empty)
  );

  // Full flag of the receive side is not reported, overflow drops bytes
  uart_fifo rx_fifo (
    .clock(clock), .reset(reset), .push(rx_push), .push_data(rx_byte),
    .pop(rx_pop), .pop_data(rx_pop_data), .level(rx_level),
    .full(), .empty(rx_empty)
  );

  uart_tx serial_tx (
    .clock(clock), .reset(reset), .txen(txen), .nstop(nstop), .div(div),
    .fifo_empty(tx_empty), .fifo_data(tx_head), .tx_pop(tx_pop), .txd(txd)
  );

  uart_rx serial_rx (
    .clock(clock), .reset(reset), .rxen(rxen), .div(div), .rxd(rxd),
    .rx_push(rx_push), .rx_data(rx_byte)
  );

endmodule

// File: logic/uart_bank.sv
module uart_bank (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             bank_wr,
  input  logic                             bank_rd,
  input  logic [2:0]                       addr,
  input  logic [31:0]                      wr_data,
  output logic [31:0]                      rd_data,
  output logic                             txen,
  output logic                             rxen,
  output logic                             nstop,
  output logic [15:0]                      div,
  output logic                             tx_push,
  output logic [7:0]                       tx_push_data,
  output logic                             rx_pop,
  input  logic [7:0]                       rx_pop_data,
  input  logic [uart_pkg::level_width-1:0] tx_level,
  input  logic                             tx_full,
  input  logic [uart_pkg::level_width-1:0] rx_level,
  input  logic                             rx_empty,
  output logic                             interrupt
);
  import uart_pkg::*;

  logic [cnt_width-1:0] txcnt;
  logic [cnt_width-1:0] rxcnt;
  logic                 ie_txwm;
  logic                 ie_rxwm;
  logic                 txwm_pend;
  logic                 rxwm_pend;
  logic [31:0]          rd_next;

  // FIFO side effects happen only on the access strobe
  assign tx_push      = bank_wr && (addr == reg_txdata) && !tx_full;
  assign tx_push_data = wr_data[7:0];
  assign rx_pop       = bank_rd && (addr == reg_rxdata) && !rx_empty;

  // Strict comparisons against the watermark fields
  assign txwm_pend = tx_level < level_width'(txcnt);
  assign rxwm_pend = rx_level > level_width'(rxcnt);
  assign interrupt = (txwm_pend & ie_txwm) | (rxwm_pend & ie_rxwm);

  always_ff @(posedge clock) begin
    if (reset) begin
      txen    <= 1'b0;
      nstop   <= 1'b0;
      txcnt   <= '0;
      rxen    <= 1'b0;
      rxcnt   <= '0;
      ie_txwm <= 1'b0;
      ie_rxwm <= 1'b0;
      div     <= div_reset;
    end else if (bank_wr) begin
      case (addr)
        reg_txctrl: begin
          txen  <= wr_data[0];
          nstop <= wr_data[1];
          txcnt <= wr_data[cnt_lsb +: cnt_width];
        end
        reg_rxctrl: begin
          rxen  <= wr_data[0];
          rxcnt <= wr_data[cnt_lsb +: cnt_width];
        end
        reg_ie: begin
          ie_txwm <= wr_data[0];
          ie_rxwm <= wr_data[1];
        end
        reg_div: begin
          div <= wr_data[15:0];
        end
        default: ;
      endcase
    end
  end

  always_comb begin
    rd_next = '0;
    case (addr)
      reg_txdata: rd_next[flag_bit] = tx_full;
      reg_rxdata: begin
        rd_next[flag_bit] = rx_empty;
        if (!rx_empty) begin
          rd_next[7:0] = rx_pop_data;
        end
      end
      reg_txctrl: begin
        rd_next[0]                     = txen;
        rd_next[1]                     = nstop;
        rd_next[cnt_lsb +: cnt_width]  = txcnt;
      end
      reg_rxctrl: begin
        rd_next[0]                     = rxen;
        rd_next[cnt_lsb +: cnt_width]  = rxcnt;
      end
      reg_ie:     rd_next[1:0] = {ie_rxwm, ie_txwm};
      reg_ip:     rd_next[1:0] = {rxwm_pend, txwm_pend};
      reg_div:    rd_next[15:0] = div;
      default:    rd_next = '0;
    endcase
  end

  // Held until the next read, valid during ack
  always_ff @(posedge clock) begin
    if (bank_rd) begin
      rd_data <= rd_next;
    end
  end

endmodule

// File: logic/uart_fifo.sv
module uart_fifo (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            push,
  input  logic [7:0]                      push_data,
  input  logic                            pop,
  output logic [7:0]                      pop_data,
  output logic [uart_pkg::level_width-1:0] level,
  output logic                            full,
  output logic                            empty
);
  import uart_pkg::*;

  logic [7:0]                    mem [fifo_depth];
  logic [$clog2(fifo_depth)-1:0] wr_ptr;
  logic [$clog2(fifo_depth)-1:0] rd_ptr;
  logic                          do_push;
  logic                          do_pop;

  assign full     = (level == level_width'(fifo_depth));
  assign empty    = (level == '0);
  assign do_push  = push & ~full;
  assign do_pop   = pop & ~empty;
  assign pop_data = mem[rd_ptr];

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        level <= level + 1'b1;
      end else if (do_pop && !do_push) begin
        level <= level - 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

// File: logic/uart_fsm.sv
module uart_fsm (
  input  logic clock,
  input  logic reset,
  input  logic cyc,
  input  logic stb,
  input  logic we,
  output logic capture,
  output logic bank_wr,
  output logic bank_rd,
  output logic ack
);
  import uart_pkg::*;

  bus_state_t state;
  bus_state_t state_next;
  logic       request;
  logic       we_q;

  assign request = cyc & stb;
  assign capture = (state == bus_idle) && request;

  // One strobe per bus cycle, direction latched with the request
  assign bank_wr = (state == bus_access) && we_q;
  assign bank_rd = (state == bus_access) && !we_q;
  assign ack     = (state == bus_ack);

  always_comb begin
    state_next = state;
    case (state)
      bus_idle: begin
        if (request) begin
          state_next = bus_access;
        end
      end
      bus_access: state_next = bus_ack;
      bus_ack:    state_next = bus_idle;
      default:    state_next = bus_idle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= bus_idle;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clock) begin
    if (capture) begin
      we_q <= we;
    end
  end

endmodule

// File: logic/uart_pkg.sv
package uart_pkg;

  // FIFO sizing
  localparam int fifo_depth  = 8;
  localparam int level_width = 4;
  localparam int cnt_width   = 3;

  // Register word indices
  localparam logic [2:0] reg_txdata = 3'd0;
  localparam logic [2:0] reg_rxdata = 3'd1;
  localparam logic [2:0] reg_txctrl = 3'd2;
  localparam logic [2:0] reg_rxctrl = 3'd3;
  localparam logic [2:0] reg_ie     = 3'd4;
  localparam logic [2:0] reg_ip     = 3'd5;
  localparam logic [2:0] reg_div    = 3'd6;

  // Field positions
  localparam int flag_bit = 31;
  localparam int cnt_lsb  = 16;

  localparam logic [15:0] div_reset = 16'd3;

  // Bus sequencer states
  typedef enum logic [1:0] {
    bus_idle,
    bus_access,
    bus_ack
  } bus_state_t;

endpackage

// File: logic/uart_rx.sv
module uart_rx (
  input  logic        clock,
  input  logic        reset,
  input  logic        rxen,
  input  logic [15:0] div,
  input  logic        rxd,
  output logic        rx_push,
  output logic [7:0]  rx_data
);

  logic        rxd_meta;
  logic        rxd_sync;
  logic        rxd_last;
  logic        busy;
  logic [15:0] baud_cnt;
  logic [3:0]  bit_idx;
  logic [7:0]  shift;
  logic        start_edge;
  logic        sample;

  assign start_edge = ~busy & rxd_last & ~rxd_sync;
  assign sample     = busy && (baud_cnt == '0);
  assign rx_data    = shift;

  // Line idles high
  always_ff @(posedge clock) begin
    if (reset) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_last <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_last <= rxd_sync;
    end
  end

  // bit_idx 0 is the start bit, 1 to 8 data, 9 the stop bit
  always_ff @(posedge clock) begin
    if (reset) begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
      rx_push  <= 1'b0;
    end else begin
      rx_push <= 1'b0;
      if (start_edge) begin
        busy     <= 1'b1;
        baud_cnt <= {1'b0, div[15:1]};
        bit_idx  <= '0;
      end else if (sample) begin
        baud_cnt <= div;
        bit_idx  <= bit_idx + 4'd1;
        if (bit_idx == 4'd0 && rxd_sync) begin
          // Glitch, not a real start bit
          busy <= 1'b0;
        end else if (bit_idx == 4'd9) begin
          busy    <= 1'b0;
          rx_push <= rxd_sync & rxen;
        end
      end else if (busy) begin
        baud_cnt <= baud_cnt - 16'd1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (sample && bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
      shift <= {rxd_sync, shift[7:1]};
    end
  end

endmodule

// File: logic/uart_tx.sv
module uart_tx (
  input  logic        clock,
  input  logic        reset,
  input  logic        txen,
  input  logic        nstop,
  input  logic [15:0] div,
  input  logic        fifo_empty,
  input  logic [7:0]  fifo_data,
  output logic        tx_pop,
  output logic        txd
);

  logic        busy;
  logic [15:0] baud_cnt;
  logic [3:0]  bits_left;
  logic [8:0]  shift;
  logic        bit_done;

  // Fetch a new byte only between frames
  assign tx_pop   = ~busy & txen & ~fifo_empty;
  assign bit_done = busy && (baud_cnt == '0);
  assign txd      = busy ? shift[0] : 1'b1;

  always_ff @(posedge clock) begin
    if (reset) begin
      busy      <= 1'b0;
      baud_cnt  <= '0;
      bits_left <= '0;
    end else if (tx_pop) begin
      busy      <= 1'b1;
      baud_cnt  <= div;
      // Start, eight data bits and one or two stop bits
      bits_left <= nstop ? 4'd11 : 4'd10;
    end else if (bit_done) begin
      baud_cnt  <= div;
      bits_left <= bits_left - 4'd1;
      if (bits_left == 4'd1) begin
        busy <= 1'b0;
      end
    end else if (busy) begin
      baud_cnt <= baud_cnt - 16'd1;
    end
  end

  // Ones shift in from the top to form the stop bits
  always_ff @(posedge clock) begin
    if (tx_pop) begin
      shift <= {fifo_data, 1'b0};
    end else if (bit_done) begin
      shift <= {1'b1, shift[8:1]};
    end
  end

endmodule

// File: uart.f
logic/uart_pkg.sv
logic/uart_fifo.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_bank.sv
logic/uart_fsm.sv
logic/uart.sv
verification/uart_assertions.sv
verification/uart_tb.sv

// File: verification/uart_assertions.sv
module uart_assertions (
  input logic clock,
  input logic reset,
  input logic capture,
  input logic ack,
  input logic txen,
  input logic tx_busy,
  input logic txd
);
  timeunit 1ns;
  timeprecision 1ps;

  int failures = 0;

  ack_single: assert property (@(posedge clock) disable iff (reset)
    ack |=> !ack)
    else begin
      failures++;
      $error("ack high for two consecutive cycles");
    end

  // Accepted request, strobe cycle, then ack
  ack_latency: assert property (@(posedge clock) disable iff (reset)
    capture |=> !ack ##1 ack)
    else begin
      failures++;
      $error("ack latency differs from two cycles");
    end

  // A disabled idle transmitter must not start a frame
  txd_idle: assert property (@(posedge clock) disable iff (reset)
    (!txen && !tx_busy) |=> txd)
    else begin
      failures++;
      $error("txd low after the transmitter was idle and disabled");
    end

endmodule

bind uart uart_assertions u_assertions (
  .clock(clock),
  .reset(reset),
  .capture(capture),
  .ack(ack),
  .txen(txen),
  .tx_busy(serial_tx.busy),
  .txd(txd)
);

// File: verification/uart_tb.sv
module uart_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import uart_pkg::*;

  typedef enum logic [2:0] {
    op_write,
    op_read,
    op_poll,
    op_wait,
    op_irq,
    op_frame
  } op_t;

  typedef struct packed {
    int          id;
    op_t         op;
    logic [2:0]  idx;
    logic [31:0] wdata;
    logic [31:0] exp;
    logic [31:0] mask;
  } entry_t;

  localparam logic [15:0] test_div   = 16'd3;
  localparam int          n_bytes    = 16;
  localparam logic [31:0] data_mask  = 32'h8000_00ff;
  localparam logic [31:0] empty_flag = 32'h8000_0000;

  logic        clock;
  logic        reset;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [2:0]  adr;
  logic [31:0] dat_i;
  logic [31:0] dat_o;
  logic        ack;
  logic        rxd;
  logic        txd;
  logic        interrupt;

  entry_t      entries[$];
  logic [7:0]  payload [n_bytes];
  int          errors = 0;
  int          wait_cycles = 0;
  int          limit = 0;
  int          cycles = 0;
  int          start_cycle = 0;
  int          frame_cycles = 0;
  logic        txd_prev = 1'b1;

  uart i_uart (
    .clock(clock), .reset(reset), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .dat_i(dat_i), .dat_o(dat_o), .ack(ack), .rxd(rxd), .txd(txd),
    .interrupt(interrupt)
  );

  // Serial loopback
  assign rxd = txd;

  always #50 clock = ~clock;

  always @(posedge clock) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("Timeout: the tests did not finish within %0d cycles", limit);
      $display("Simulation failed");
      $finish;
    end
  end

  // Start-to-start spacing of frames on txd, data bit edges skipped
  always @(negedge clock) begin
    if (txd_prev === 1'b1 && txd === 1'b0 &&
        cycles - start_cycle >= 9 * (int'(test_div) + 1)) begin
      frame_cycles = cycles - start_cycle;
      start_cycle  = cycles;
    end
    txd_prev = txd;
  end

  task automatic add_entry(input int id, input op_t op, input logic [2:0] idx,
                           input logic [31:0] wdata, input logic [31:0] exp,
                           input logic [31:0] mask);
    entry_t e;
    e = '{id, op, idx, wdata, exp, mask};
    entries.push_back(e);
    if (op == op_wait) begin
      wait_cycles += int'(wdata);
    end
  endtask

  task automatic build_table();
    int k;
    // Reset values
    add_entry(1, op_read, reg_div, 32'h0, 32'(div_reset), 32'h0000_ffff);
    add_entry(1, op_read, reg_txctrl, 32'h0, 32'h0, 32'h0007_0003);
    add_entry(1, op_read, reg_rxctrl, 32'h0, 32'h0, 32'h0007_0001);
    add_entry(1, op_read, reg_ie, 32'h0, 32'h0, 32'h3);
    add_entry(1, op_read, reg_ip, 32'h0, 32'h0, 32'h3);
    add_entry(1, op_read, reg_rxdata, 32'h0, empty_flag, empty_flag);
    add_entry(1, op_read, reg_txdata, 32'h0, 32'h0, empty_flag);
    // Register read-back
    add_entry(2, op_write, reg_div, 32'h0000_5a3c, 32'h0, 32'h0);
    add_entry(2, op_read, reg_div, 32'h0, 32'h0000_5a3c, 32'h0000_ffff);
    add_entry(2, op_write, reg_div, 32'(test_div), 32'h0, 32'h0);
    add_entry(2, op_read, reg_div, 32'h0, 32'(test_div), 32'h0000_ffff);
    add_entry(2, op_write, reg_txctrl, 32'h0005_0003, 32'h0, 32'h0);
    add_entry(2, op_read, reg_txctrl, 32'h0, 32'h0005_0003, 32'h0007_0003);
    add_entry(2, op_write, reg_rxctrl, 32'h0006_0001, 32'h0, 32'h0);
    add_entry(2, op_read, reg_rxctrl, 32'h0, 32'h0006_0001, 32'h0007_0001);
    // Loopback of four bytes
    add_entry(3, op_write, reg_rxctrl, 32'h1, 32'h0, 32'h0);
    add_entry(3, op_write, reg_txctrl, 32'h1, 32'h0, 32'h0);
    for (k = 0; k < 4; k++) begin
      add_entry(3, op_write, reg_txdata, {24'h0, payload[k]}, 32'h0, 32'h0);
    end
    for (k = 0; k < 4; k++) begin
      add_entry(3, op_poll, reg_rxdata, 32'h0, {24'h0, payload[k]}, data_mask);
    end
    add_entry(3, op_read, reg_rxdata, 32'h0, empty_flag, empty_flag);
    // Ninth byte finds the FIFO full
    add_entry(4, op_write, reg_txctrl, 32'h0, 32'h0, 32'h0);
    for (k = 4; k < 12; k++) begin
      add_entry(4, op_write, reg_txdata, {24'h0, payload[k]}, 32'h0, 32'h0);
    end
    add_entry(4, op_read, reg_txdata, 32'h0, empty_flag, empty_flag);
    add_entry(4, op_write, reg_txdata, {24'h0, payload[12]}, 32'h0, 32'h0);
    add_entry(4, op_write, reg_txctrl, 32'h1, 32'h0, 32'h0);
    for (k = 4; k < 12; k++) begin
      add_entry(4, op_poll, reg_rxdata, 32'h0, {24'h0, payload[k]}, data_mask);
    end
    add_entry(4, op_frame, 3'd0, 32'h0, 32'd10, 32'hffff_ffff);
    add_entry(4, op_wait, 3'd0, 32'd100, 32'h0, 32'h0);
    add_entry(4, op_read, reg_rxdata, 32'h0, empty_flag, empty_flag);
    // txwm when level < txcnt, rxwm when level > rxcnt
    add_entry(5, op_write, reg_txctrl, 32'h0001_0000, 32'h0, 32'h0);
    add_entry(5, op_write, reg_ie, 32'h1, 32'h0, 32'h0);
    add_entry(5, op_read, reg_ip, 32'h0, 32'h1, 32'h3);
    add_entry(5, op_irq, 3'd0, 32'h0, 32'h1, 32'h1);
    add_entry(5, op_write, reg_rxctrl, 32'h1, 32'h0, 32'h0);
    add_entry(5, op_write, reg_ie, 32'h2, 32'h0, 32'h0);
    add_entry(5, op_write, reg_txctrl, 32'h1, 32'h0, 32'h0);
    add_entry(5, op_write, reg_txdata, {24'h0, payload[13]}, 32'h0, 32'h0);
    add_entry(5, op_wait, 3'd0, 32'd80, 32'h0, 32'h0);
    add_entry(5, op_read, reg_ip, 32'h0, 32'h2, 32'h3);
    add_entry(5, op_irq, 3'd0, 32'h0, 32'h1, 32'h1);
    add_entry(5, op_read, reg_rxdata, 32'h0, {24'h0, payload[13]}, data_mask);
    add_entry(5, op_read, reg_ip, 32'h0, 32'h0, 32'h3);
    add_entry(5, op_irq, 3'd0, 32'h0, 32'h0, 32'h1);
    // Two stop bits
    add_entry(6, op_write, reg_txctrl, 32'h3, 32'h0, 32'h0);
    for (k = 14; k < 16; k++) begin
      add_entry(6, op_write, reg_txdata, {24'h0, payload[k]}, 32'h0, 32'h0);
    end
    for (k = 14; k < 16; k++) begin
      add_entry(6, op_poll, reg_rxdata, 32'h0, {24'h0, payload[k]}, data_mask);
    end
    add_entry(6, op_frame, 3'd0, 32'h0, 32'd11, 32'hffff_ffff);
    add_entry(6, op_read, reg_rxdata, 32'h0, empty_flag, empty_flag);
  endtask

  task automatic bus_access(input logic is_write, input logic [2:0] idx,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic early, output logic acked);
    @(posedge clock);
    #1;
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = is_write;
    adr   = idx;
    dat_i = wdata;
    @(posedge clock);
    #1;
    early = ack;
    @(posedge clock);
    #1;
    acked = ack;
    rdata = dat_o;
    // Request is released in the cycle after ack
    @(posedge clock);
    #1;
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic check_ack(input int id, input logic early, input logic acked);
    assert (!early && acked) else begin
      $display("Test %0d: ack did not come exactly two cycles after the request", id);
      errors++;
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act, input logic [31:0] mask);
    assert ((act & mask) == (exp & mask)) else begin
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp & mask,
               act & mask);
      errors++;
    end
  endtask

  task automatic run_entry(input entry_t e);
    logic [31:0] rdata;
    logic        early;
    logic        acked;
    case (e.op)
      op_write: begin
        bus_access(1'b1, e.idx, e.wdata, rdata, early, acked);
        check_ack(e.id, early, acked);
      end
      op_read: begin
        bus_access(1'b0, e.idx, 32'h0, rdata, early, acked);
        check_ack(e.id, early, acked);
        if (acked) begin
          check_value("dat_o", e.exp, rdata, e.mask);
        end
      end
      op_poll: begin
        // A read of a non-empty FIFO pops, so stop at the first byte
        do begin
          bus_access(1'b0, e.idx, 32'h0, rdata, early, acked);
          check_ack(e.id, early, acked);
        end while (acked && rdata[flag_bit]);
        if (acked) begin
          check_value("dat_o", e.exp, rdata, e.mask);
        end
      end
      op_wait: repeat (e.wdata) @(posedge clock);
      op_irq: begin
        @(posedge clock);
        #1;
        check_value("interrupt", e.exp, {31'h0, interrupt}, e.mask);
      end
      // Whole bit periods between back-to-back start bits
      op_frame: begin
        check_value("txd", e.exp, frame_cycles / (int'(test_div) + 1), e.mask);
      end
      default: ;
    endcase
  endtask

  initial begin
    int k;
    int n;
    int test_errors;
    int passed_tests;
    int failed_tests;
    clock = 1'b0;
    reset = 1'b1;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    dat_i = '0;
    passed_tests = 0;
    failed_tests = 0;
    void'($urandom(81));
    for (k = 0; k < n_bytes; k++) begin
      payload[k] = 8'($urandom());
    end
    build_table();
    limit = n_bytes * 11 * (int'(test_div) + 1) + entries.size() * 4 + wait_cycles + 200;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
    test_errors = 0;
    for (n = 0; n < entries.size(); n++) begin
      run_entry(entries[n]);
      if (n == entries.size() - 1 || entries[n + 1].id != entries[n].id) begin
        if (errors == test_errors) begin
          $display("Test %0d passed", entries[n].id);
          passed_tests++;
        end else begin
          $display("Test %0d failed with %0d errors", entries[n].id, errors - test_errors);
          failed_tests++;
        end
        test_errors = errors;
      end
    end
    $display("Tests passed: %0d, tests failed: %0d, assertion failures: %0d",
             passed_tests, failed_tests, i_uart.u_assertions.failures);
    if (failed_tests == 0 && i_uart.u_assertions.failures == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
